// ==== hw/cache_pkg.sv ====
// data cache widths, cache line type, core and memory request and response structs
package cache_pkg;

    localparam int WORD_WIDTH      = 32;
    localparam int WORD_BYTES      = WORD_WIDTH / 8;
    localparam int WORDS_PER_LINE  = 4;
    localparam int WSEL_WIDTH      = 2;
    localparam int LINE_ADDR_WIDTH = 14;
    localparam int CORE_TAG_WIDTH  = 4;

    typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] line_t;

    // rw = 1 is a write
    typedef struct packed {
        logic                       rw;
        logic [LINE_ADDR_WIDTH-1:0] line_addr;
        logic [WSEL_WIDTH-1:0]      wsel;
        logic [WORD_BYTES-1:0]      byteen;
        logic [WORD_WIDTH-1:0]      data;
        logic [CORE_TAG_WIDTH-1:0]  tag;
    } core_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0]     data;
        logic [CORE_TAG_WIDTH-1:0] tag;
    } core_rsp_t;

    // data is zero on a line fill request
    typedef struct packed {
        logic                       rw;
        logic [LINE_ADDR_WIDTH-1:0] line_addr;
        logic [WSEL_WIDTH-1:0]      wsel;
        logic [WORD_BYTES-1:0]      byteen;
        logic [WORD_WIDTH-1:0]      data;
    } mem_req_t;

    // single outstanding fill, so no address comes back
    typedef struct packed {
        line_t data;
    } mem_rsp_t;

endpackage

// ==== hw/bank_fifo.sv ====
// payload-typed circular FIFO with count and almost-full flag
`timescale 1ns/1ps

module bank_fifo #(
    parameter int  QUEUE_DEPTH = 4,
    parameter type payload_t   = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     pop_valid,
    output payload_t pop_data,
    input  logic     pop_ready,
    output logic     alm_full
);

    localparam int PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);

    payload_t           fifo_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [COUNT_W-1:0] count;
    logic               pop;
    logic               full;

    assign pop_valid = (count != '0);
    assign pop_data  = fifo_mem[rd_ptr];
    assign pop       = pop_valid && pop_ready;
    assign full      = (count == COUNT_W'(QUEUE_DEPTH));
    // at most one free slot
    assign alm_full  = (count >= COUNT_W'(QUEUE_DEPTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= push_data;
        end
    end

    // the producer throttles on alm_full, so a push never meets a full queue
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(push && full)
    ) else $error("push into a full queue");

endmodule

// ==== hw/bank_tags.sv ====
// direct-mapped tag array and valid bits with registered read and line fill
`timescale 1ns/1ps

module bank_tags #(
    parameter int  NUM_LINES = 64,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = cache_pkg::LINE_ADDR_WIDTH - IDX_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [IDX_W-1:0] rd_idx,
    input  logic             fill,
    input  logic [IDX_W-1:0] fill_idx,
    input  logic [TAG_W-1:0] fill_tag,
    output logic [TAG_W-1:0] rd_tag,
    output logic             rd_valid
);
    import cache_pkg::*;

    logic [TAG_W-1:0]     tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    // valid bits clear on reset so the bank starts empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= valid_q[rd_idx];
            if (fill) begin
                valid_q[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_tag <= tag_mem[rd_idx];
        if (fill) begin
            tag_mem[fill_idx] <= fill_tag;
        end
    end

    // hit logic in stage 1 depends on a known valid bit
    a_rd_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(rd_valid)
    ) else $error("tag store returned an unknown valid bit");

    // stored tag must keep the top of the line address
    initial begin
        assert (TAG_W > 0 && TAG_W < LINE_ADDR_WIDTH)
            else $error("NUM_LINES leaves no room for a tag");
    end

endmodule

// ==== hw/bank_data.sv ====
// cache line store with registered read, line fill and byte-enabled word write
`timescale 1ns/1ps

module bank_data #(
    parameter int  NUM_LINES = 64,
    localparam int IDX_W     = $clog2(NUM_LINES)
) (
    input  logic                                 clk,
    input  logic [IDX_W-1:0]                     rd_idx,
    output cache_pkg::line_t                     rd_line,
    input  logic                                 fill,
    input  logic [IDX_W-1:0]                     fill_idx,
    input  cache_pkg::line_t                     fill_line,
    input  logic                                 wr,
    input  logic [IDX_W-1:0]                     wr_idx,
    input  logic [cache_pkg::WSEL_WIDTH-1:0]     wr_wsel,
    input  logic [cache_pkg::WORD_BYTES-1:0]     wr_byteen,
    input  logic [cache_pkg::WORD_WIDTH-1:0]     wr_word
);
    import cache_pkg::*;

    line_t data_mem [NUM_LINES];

    // read returns the old line when the same index is written at this edge
    always_ff @(posedge clk) begin
        rd_line <= data_mem[rd_idx];
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            data_mem[fill_idx] <= fill_line;
        end else if (wr) begin
            // merge only the enabled bytes into the selected word
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (wr_byteen[b]) begin
                    data_mem[wr_idx][wr_wsel][b*8 +: 8] <= wr_word[b*8 +: 8];
                end
            end
        end
    end

    // fills only come while a read miss blocks the bank, so no write hit can be in flight
    a_no_fill_and_write: assert property (
        @(posedge clk) !(fill && wr)
    ) else $error("line fill and word write in the same cycle");

endmodule

// ==== hw/bank_pipeline.sv ====
// request arbitration, stage 1 hit and miss, miss register, hazard stall and queue pushes
`timescale 1ns/1ps

module bank_pipeline #(
    parameter int  NUM_LINES = 64,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = cache_pkg::LINE_ADDR_WIDTH - IDX_W
) (
    input  logic                             clk,
    input  logic                             rst_n,

    input  cache_pkg::core_req_t             core_req,
    input  logic                             core_req_valid,
    output logic                             core_req_ready,
    input  cache_pkg::mem_rsp_t              mem_rsp,
    input  logic                             mem_rsp_valid,
    output logic                             mem_rsp_ready,

    output logic [IDX_W-1:0]                 tag_rd_idx,
    output logic                             tag_fill,
    output logic [TAG_W-1:0]                 tag_fill_tag,
    input  logic [TAG_W-1:0]                 tag_rd_tag,
    input  logic                             tag_rd_valid,

    output logic [IDX_W-1:0]                 data_rd_idx,
    output logic                             data_fill,
    output cache_pkg::line_t                 data_fill_line,
    output logic                             data_wr,
    output logic [IDX_W-1:0]                 data_wr_idx,
    output logic [cache_pkg::WSEL_WIDTH-1:0] data_wr_wsel,
    output logic [cache_pkg::WORD_BYTES-1:0] data_wr_byteen,
    output logic [cache_pkg::WORD_WIDTH-1:0] data_wr_word,
    input  cache_pkg::line_t                 data_rd_line,

    output logic                             rsp_push,
    output cache_pkg::core_rsp_t             rsp_data,
    input  logic                             rsp_alm_full,
    output logic                             mreq_push,
    output cache_pkg::mem_req_t              mreq_data,
    input  logic                             mreq_alm_full
);
    import cache_pkg::*;

    logic      run_q;
    logic      s1_valid;
    core_req_t s1_req;

    // the single outstanding read miss
    logic                       miss_pending;
    logic [LINE_ADDR_WIDTH-1:0] miss_line_addr;
    logic [WSEL_WIDTH-1:0]      miss_wsel;
    logic [CORE_TAG_WIDTH-1:0]  miss_tag;

    logic             s1_hit;
    logic             s1_rd_hit;
    logic             s1_rd_miss;
    logic             s1_wr;
    logic             s1_wr_hit;
    logic             hazard_stall;
    logic             core_req_fire;
    logic             mem_rsp_fire;
    logic [IDX_W-1:0] arr_idx;

    // stage 1 lookup
    assign s1_hit     = tag_rd_valid && (tag_rd_tag == s1_req.line_addr[LINE_ADDR_WIDTH-1:IDX_W]);
    assign s1_rd_hit  = s1_valid && !s1_req.rw && s1_hit;
    assign s1_rd_miss = s1_valid && !s1_req.rw && !s1_hit;
    assign s1_wr      = s1_valid && s1_req.rw;
    assign s1_wr_hit  = s1_wr && s1_hit;

    // read after a write hit to the same line must wait one cycle
    assign hazard_stall = s1_wr_hit && (core_req.line_addr == s1_req.line_addr);

    // fills win over core requests; a miss in stage 1 already blocks new requests
    assign core_req_ready = run_q && !miss_pending && !s1_rd_miss && !mem_rsp_valid
                          && !rsp_alm_full && !mreq_alm_full && !hazard_stall;
    assign mem_rsp_ready  = miss_pending && !rsp_alm_full;
    assign core_req_fire  = core_req_valid && core_req_ready;
    assign mem_rsp_fire   = mem_rsp_valid && mem_rsp_ready;

    // array index points at the miss line while a fill is pending
    assign arr_idx     = miss_pending ? miss_line_addr[IDX_W-1:0] : core_req.line_addr[IDX_W-1:0];
    assign tag_rd_idx  = arr_idx;
    assign data_rd_idx = arr_idx;

    assign tag_fill       = mem_rsp_fire;
    assign tag_fill_tag   = miss_line_addr[LINE_ADDR_WIDTH-1:IDX_W];
    assign data_fill      = mem_rsp_fire;
    assign data_fill_line = mem_rsp.data;

    assign data_wr        = s1_wr_hit;
    assign data_wr_idx    = s1_req.line_addr[IDX_W-1:0];
    assign data_wr_wsel   = s1_req.wsel;
    assign data_wr_byteen = s1_req.byteen;
    assign data_wr_word   = s1_req.data;

    // responses come from a read hit or from the returning fill and never both at once
    assign rsp_push = s1_rd_hit || mem_rsp_fire;
    always_comb begin
        if (mem_rsp_fire) begin
            rsp_data.data = mem_rsp.data[miss_wsel];
            rsp_data.tag  = miss_tag;
        end else begin
            rsp_data.data = data_rd_line[s1_req.wsel];
            rsp_data.tag  = s1_req.tag;
        end
    end

    // fill request on a read miss and write-through on every write
    assign mreq_push = s1_rd_miss || s1_wr;
    always_comb begin
        mreq_data.rw        = s1_req.rw;
        mreq_data.line_addr = s1_req.line_addr;
        mreq_data.wsel      = s1_req.wsel;
        mreq_data.byteen    = s1_req.byteen;
        mreq_data.data      = s1_req.rw ? s1_req.data : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q        <= 1'b0;
            s1_valid     <= 1'b0;
            miss_pending <= 1'b0;
        end else begin
            run_q    <= 1'b1;
            s1_valid <= core_req_fire;
            if (s1_rd_miss) begin
                miss_pending <= 1'b1;
            end else if (mem_rsp_fire) begin
                miss_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (core_req_fire) begin
            s1_req <= core_req;
        end
        if (s1_rd_miss) begin
            miss_line_addr <= s1_req.line_addr;
            miss_wsel      <= s1_req.wsel;
            miss_tag       <= s1_req.tag;
        end
    end

    // memory only offers a fill for the pending miss
    a_fill_needs_miss: assert property (
        @(posedge clk) disable iff (!rst_n) mem_rsp_valid |-> miss_pending
    ) else $error("memory fill offered without a pending miss");

    // no request reaches stage 1 while a miss is pending
    a_blocked_on_miss: assert property (
        @(posedge clk) disable iff (!rst_n) miss_pending |-> !s1_valid
    ) else $error("core request accepted while a miss is pending");

endmodule

// ==== hw/cache_bank.sv ====
// write-through direct-mapped cache bank top level with pipeline, tag and data stores and queues
`timescale 1ns/1ps

module cache_bank #(
    parameter int NUM_LINES   = 64,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  cache_pkg::core_req_t core_req,
    input  logic                 core_req_valid,
    output logic                 core_req_ready,

    output cache_pkg::core_rsp_t core_rsp,
    output logic                 core_rsp_valid,
    input  logic                 core_rsp_ready,

    output cache_pkg::mem_req_t  mem_req,
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,

    input  cache_pkg::mem_rsp_t  mem_rsp,
    input  logic                 mem_rsp_valid,
    output logic                 mem_rsp_ready
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = LINE_ADDR_WIDTH - IDX_W;

    // tag store
    logic [IDX_W-1:0] tag_rd_idx;
    logic             tag_fill;
    logic [TAG_W-1:0] tag_fill_tag;
    logic [TAG_W-1:0] tag_rd_tag;
    logic             tag_rd_valid;

    // data store
    logic [IDX_W-1:0]      data_rd_idx;
    logic                  data_fill;
    line_t                 data_fill_line;
    logic                  data_wr;
    logic [IDX_W-1:0]      data_wr_idx;
    logic [WSEL_WIDTH-1:0] data_wr_wsel;
    logic [WORD_BYTES-1:0] data_wr_byteen;
    logic [WORD_WIDTH-1:0] data_wr_word;
    line_t                 data_rd_line;

    // queues
    logic      rsp_push;
    core_rsp_t rsp_data;
    logic      rsp_alm_full;
    logic      mreq_push;
    mem_req_t  mreq_data;
    logic      mreq_alm_full;

    bank_pipeline #(
        .NUM_LINES (NUM_LINES)
    ) pipeline_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .mem_rsp        (mem_rsp),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .tag_rd_idx     (tag_rd_idx),
        .tag_fill       (tag_fill),
        .tag_fill_tag   (tag_fill_tag),
        .tag_rd_tag     (tag_rd_tag),
        .tag_rd_valid   (tag_rd_valid),
        .data_rd_idx    (data_rd_idx),
        .data_fill      (data_fill),
        .data_fill_line (data_fill_line),
        .data_wr        (data_wr),
        .data_wr_idx    (data_wr_idx),
        .data_wr_wsel   (data_wr_wsel),
        .data_wr_byteen (data_wr_byteen),
        .data_wr_word   (data_wr_word),
        .data_rd_line   (data_rd_line),
        .rsp_push       (rsp_push),
        .rsp_data       (rsp_data),
        .rsp_alm_full   (rsp_alm_full),
        .mreq_push      (mreq_push),
        .mreq_data      (mreq_data),
        .mreq_alm_full  (mreq_alm_full)
    );

    // fills reuse the read index, which points at the miss line while a fill is pending
    bank_tags #(
        .NUM_LINES (NUM_LINES)
    ) tags_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_idx   (tag_rd_idx),
        .fill     (tag_fill),
        .fill_idx (tag_rd_idx),
        .fill_tag (tag_fill_tag),
        .rd_tag   (tag_rd_tag),
        .rd_valid (tag_rd_valid)
    );

    bank_data #(
        .NUM_LINES (NUM_LINES)
    ) data_inst (
        .clk       (clk),
        .rd_idx    (data_rd_idx),
        .rd_line   (data_rd_line),
        .fill      (data_fill),
        .fill_idx  (data_rd_idx),
        .fill_line (data_fill_line),
        .wr        (data_wr),
        .wr_idx    (data_wr_idx),
        .wr_wsel   (data_wr_wsel),
        .wr_byteen (data_wr_byteen),
        .wr_word   (data_wr_word)
    );

    bank_fifo #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .payload_t   (core_rsp_t)
    ) core_rsp_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rsp_push),
        .push_data (rsp_data),
        .pop_valid (core_rsp_valid),
        .pop_data  (core_rsp),
        .pop_ready (core_rsp_ready),
        .alm_full  (rsp_alm_full)
    );

    bank_fifo #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .payload_t   (mem_req_t)
    ) mem_req_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (mreq_push),
        .push_data (mreq_data),
        .pop_valid (mem_req_valid),
        .pop_data  (mem_req),
        .pop_ready (mem_req_ready),
        .alm_full  (mreq_alm_full)
    );

endmodule

// ==== dv/tb_cache_bank.sv ====
// cache bank testbench with clock, reset, memory model, scoreboard, directed and random tests
`timescale 1ns/1ps

module tb_cache_bank;
    import cache_pkg::*;

    localparam int NUM_LINES    = 64;
    localparam int QUEUE_DEPTH  = 4;
    localparam int MODEL_LINES  = 256;
    localparam int MODEL_WORDS  = MODEL_LINES * WORDS_PER_LINE;
    localparam int REQ_TIMEOUT  = 200;
    localparam int IDLE_TIMEOUT = 1000;

    logic      clk;
    logic      rst_n;
    core_req_t core_req;
    logic      core_req_valid;
    logic      core_req_ready;
    core_rsp_t core_rsp;
    logic      core_rsp_valid;
    logic      core_rsp_ready;
    mem_req_t  mem_req;
    logic      mem_req_valid;
    logic      mem_req_ready;
    mem_rsp_t  mem_rsp;
    logic      mem_rsp_valid;
    logic      mem_rsp_ready;

    integer seed = 89;

    // memory contents and the core's view of them at accept time
    logic [WORD_WIDTH-1:0] model_words [MODEL_WORDS];
    logic [WORD_WIDTH-1:0] ref_words   [MODEL_WORDS];

    // line held by each cache index under direct-mapped, no-write-allocate rules
    logic                       ref_valid [NUM_LINES];
    logic [LINE_ADDR_WIDTH-1:0] ref_line  [NUM_LINES];

    core_rsp_t exp_rsp  [$];
    mem_req_t  exp_mreq [$];
    mem_req_t  mem_log  [$];
    int        rsp_seen;
    int        mreq_seen;
    logic      fill_pending;
    int        error_count;
    int        tests_passed;
    int        tests_failed;
    logic      throttle;
    logic [CORE_TAG_WIDTH-1:0] next_tag;

    cache_bank #(
        .NUM_LINES   (NUM_LINES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) cache_bank_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp        (mem_rsp),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10;
            clk = ~clk;
        end
    end

    // initial memory word differs for every word address
    function automatic logic [WORD_WIDTH-1:0] pattern_word(int widx);
        logic [31:0] a;
        a = 32'(widx);
        return {~a[15:0], a[15:0]} ^ 32'h3c5a_0000;
    endfunction

    function automatic int word_index(logic [LINE_ADDR_WIDTH-1:0] line_addr, int wsel);
        return int'(line_addr) * WORDS_PER_LINE + wsel;
    endfunction

    function automatic logic [WORD_WIDTH-1:0] merge_bytes(logic [WORD_WIDTH-1:0] old_word,
                                                          logic [WORD_WIDTH-1:0] new_word,
                                                          logic [WORD_BYTES-1:0] byteen);
        logic [WORD_WIDTH-1:0] result;
        result = old_word;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (byteen[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic bank_idle();
        return rsp_seen == exp_rsp.size() && mreq_seen == exp_mreq.size()
            && !fill_pending && !mem_rsp_valid;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%0t: %s ok", $time, name);
        end else begin
            tests_failed++;
            $display("%0t: %s failed with %0d errors", $time, name, error_count - errors_before);
        end
    endtask

    // expected memory traffic and response are decided when the bank takes the request
    task automatic record_accept(input core_req_t req);
        int        idx;
        int        widx;
        mem_req_t  mreq;
        core_rsp_t rsp;
        idx            = int'(req.line_addr) % NUM_LINES;
        widx           = word_index(req.line_addr, int'(req.wsel));
        mreq.rw        = req.rw;
        mreq.line_addr = req.line_addr;
        mreq.wsel      = req.wsel;
        mreq.byteen    = req.byteen;
        mreq.data      = req.rw ? req.data : '0;
        if (req.rw) begin
            ref_words[widx] = merge_bytes(ref_words[widx], req.data, req.byteen);
            exp_mreq.push_back(mreq);
        end else begin
            if (!(ref_valid[idx] && ref_line[idx] == req.line_addr)) begin
                exp_mreq.push_back(mreq);
                ref_valid[idx] = 1'b1;
                ref_line[idx]  = req.line_addr;
            end
            rsp.data = ref_words[widx];
            rsp.tag  = req.tag;
            exp_rsp.push_back(rsp);
        end
    endtask

    // called just after a rising edge and returns just after the edge that took the request
    task automatic send_req(input logic rw, input int line_addr, input int wsel,
                            input logic [WORD_BYTES-1:0] byteen,
                            input logic [WORD_WIDTH-1:0] data);
        core_req_t req;
        int        waited;
        req.rw         = rw;
        req.line_addr  = LINE_ADDR_WIDTH'(line_addr);
        req.wsel       = WSEL_WIDTH'(wsel);
        req.byteen     = byteen;
        req.data       = data;
        req.tag        = next_tag;
        next_tag       = next_tag + CORE_TAG_WIDTH'(1);
        core_req       = req;
        core_req_valid = 1'b1;
        waited         = 0;
        @(negedge clk);
        while (!core_req_ready && waited < REQ_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!core_req_ready) begin
            abort_run("timed out waiting for the bank to accept a core request");
        end else begin
            record_accept(req);
            @(posedge clk);
            #1;
            core_req_valid = 1'b0;
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!bank_idle() && waited < IDLE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!bank_idle()) begin
            abort_run("timed out waiting for responses and memory requests to drain");
        end else begin
            #1;
        end
    endtask

    // memory model and output checks sample mid-cycle and drive just after the rising edge
    initial begin : memory_side
        int                         r;
        int                         widx;
        int                         fill_delay;
        int                         after_reset;
        logic                       fill_taken;
        logic [LINE_ADDR_WIDTH-1:0] fill_addr;
        core_rsp_t                  exp_r;
        mem_req_t                   exp_m;
        core_rsp_ready = 1'b1;
        mem_req_ready  = 1'b1;
        mem_rsp        = '0;
        mem_rsp_valid  = 1'b0;
        fill_pending   = 1'b0;
        fill_taken     = 1'b0;
        fill_delay     = 0;
        fill_addr      = '0;
        after_reset    = 0;
        rsp_seen       = 0;
        mreq_seen      = 0;
        error_count    = 0;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            model_words[i] = pattern_word(i);
        end
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                assert (!core_req_ready && !mem_rsp_ready)
                    else report_error("ready output high during reset");
            end
            if (!rst_n || after_reset < 2) begin
                assert (!core_rsp_valid && !mem_req_valid)
                    else report_error("valid output high during or right after reset");
            end
            after_reset = !rst_n ? 0 : (after_reset < 2 ? after_reset + 1 : after_reset);

            if (rst_n && core_rsp_valid && core_rsp_ready) begin
                assert (rsp_seen < exp_rsp.size())
                    else report_error("core response with no read outstanding");
                if (rsp_seen < exp_rsp.size()) begin
                    exp_r = exp_rsp[rsp_seen];
                    rsp_seen++;
                    assert (core_rsp.tag == exp_r.tag)
                        else report_error($sformatf("response tag %0h, expected %0h",
                                                    core_rsp.tag, exp_r.tag));
                    assert (core_rsp.data == exp_r.data)
                        else report_error($sformatf("response data %08h, expected %08h",
                                                    core_rsp.data, exp_r.data));
                end
            end

            if (rst_n && mem_req_valid && mem_req_ready) begin
                mem_log.push_back(mem_req);
                assert (mreq_seen < exp_mreq.size())
                    else report_error("memory request that no core request explains");
                assert (int'(mem_req.line_addr) < MODEL_LINES)
                    else report_error("memory request outside the memory model");
                if (mreq_seen < exp_mreq.size() && int'(mem_req.line_addr) < MODEL_LINES) begin
                    exp_m = exp_mreq[mreq_seen];
                    mreq_seen++;
                    assert (mem_req.rw == exp_m.rw && mem_req.line_addr == exp_m.line_addr)
                        else report_error($sformatf(
                            "memory request rw %0b line %0h, expected rw %0b line %0h",
                            mem_req.rw, mem_req.line_addr, exp_m.rw, exp_m.line_addr));
                    if (mem_req.rw) begin
                        assert (mem_req.wsel == exp_m.wsel && mem_req.byteen == exp_m.byteen
                                && mem_req.data == exp_m.data)
                            else report_error($sformatf(
                                "write-through %0h/%0h/%08h, expected %0h/%0h/%08h",
                                mem_req.wsel, mem_req.byteen, mem_req.data,
                                exp_m.wsel, exp_m.byteen, exp_m.data));
                        widx = word_index(mem_req.line_addr, int'(mem_req.wsel));
                        model_words[widx] = merge_bytes(model_words[widx], mem_req.data,
                                                        mem_req.byteen);
                    end else begin
                        assert (mem_req.data == '0)
                            else report_error("fill request with nonzero data");
                        assert (!fill_pending)
                            else report_error("second fill request while one is outstanding");
                        r            = $random(seed);
                        fill_pending = 1'b1;
                        fill_addr    = mem_req.line_addr;
                        fill_delay   = 1 + (r & 3);
                    end
                end
            end
            if (rst_n && mem_rsp_valid && mem_rsp_ready) begin
                fill_taken = 1'b1;
            end

            @(posedge clk);
            #1;
            if (fill_taken) begin
                mem_rsp_valid = 1'b0;
                fill_taken    = 1'b0;
                fill_pending  = 1'b0;
            end else if (fill_pending && !mem_rsp_valid) begin
                fill_delay--;
                // line content as memory holds it when the fill is sent
                if (fill_delay <= 0) begin
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        mem_rsp.data[w] = model_words[word_index(fill_addr, w)];
                    end
                    mem_rsp_valid = 1'b1;
                end
            end
            r              = $random(seed);
            core_rsp_ready = throttle ? r[0] : 1'b1;
            mem_req_ready  = throttle ? r[1] : 1'b1;
        end
    end

    initial begin : main_flow
        int r;
        int errors_before;
        rst_n          = 1'b0;
        core_req       = '0;
        core_req_valid = 1'b0;
        throttle       = 1'b0;
        next_tag       = '0;
        tests_passed   = 0;
        tests_failed   = 0;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            ref_words[i] = pattern_word(i);
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_line[i]  = '0;
        end
        errors_before = error_count;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (3) @(posedge clk);
        #1;
        finish_test("reset", errors_before);

        errors_before = error_count;
        send_req(1'b0, 5, 2, 4'b0000, 32'h0);
        wait_idle();
        finish_test("read miss", errors_before);

        errors_before = error_count;
        send_req(1'b0, 5, 0, 4'b0000, 32'h0);
        send_req(1'b0, 5, 3, 4'b0000, 32'h0);
        wait_idle();
        finish_test("read hit", errors_before);

        // second read right behind the write hits the hazard stall
        errors_before = error_count;
        send_req(1'b1, 5, 1, 4'b0110, 32'hdead_beef);
        send_req(1'b0, 5, 1, 4'b0000, 32'h0);
        send_req(1'b1, 5, 3, 4'b1111, 32'h0bad_f00d);
        send_req(1'b0, 5, 2, 4'b0000, 32'h0);
        send_req(1'b0, 5, 3, 4'b0000, 32'h0);
        wait_idle();
        finish_test("write-through", errors_before);

        errors_before = error_count;
        send_req(1'b1, 40, 0, 4'b1001, 32'h1122_3344);
        send_req(1'b1, 69, 2, 4'b0011, 32'h5566_7788);
        send_req(1'b0, 40, 0, 4'b0000, 32'h0);
        send_req(1'b0, 5, 2, 4'b0000, 32'h0);
        wait_idle();
        finish_test("write miss", errors_before);

        // lines 0-15 and 64-79 share indexes, so hits, misses and evictions mix
        errors_before = error_count;
        throttle      = 1'b1;
        repeat (80) begin
            r = $random(seed);
            send_req(r[8], (r & 15) + ((r >> 4) & 1) * 64, (r >> 5) & 3,
                     WORD_BYTES'(r >> 9), 32'($random(seed)));
            if (r[13]) begin
                @(posedge clk);
                #1;
            end
        end
        throttle = 1'b0;
        wait_idle();
        finish_test("back-pressure", errors_before);

        $display("tests: %0d passed, %0d failed, %0d errors, %0d memory requests",
                 tests_passed, tests_failed, error_count, mem_log.size());
        if (tests_failed == 0 && error_count == 0 && mem_log.size() == exp_mreq.size()) begin
            $display("TEST PASSED");
        end else begin
            if (mem_log.size() != exp_mreq.size()) begin
                $display("memory saw %0d requests but %0d were expected",
                         mem_log.size(), exp_mreq.size());
            end
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== cache_bank.f ====
hw/cache_pkg.sv
hw/bank_fifo.sv
hw/bank_tags.sv
hw/bank_data.sv
hw/bank_pipeline.sv
hw/cache_bank.sv
dv/tb_cache_bank.sv

// ==== run.sh ====
#!/bin/sh
# build the cache bank testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cache_bank -f cache_bank.f -o sim_cache_bank
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_cache_bank)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
